/* hdl/mac_accumulator.sv */
`timescale 1ns/1ns
//////////////////////////////////////////////////
// Sum wraps at 24 bits, overflow is sticky
// Clear wins over an add on the same edge
//////////////////////////////////////////////////
module mac_accumulator
    import mul_periph_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [PRODUCT_WIDTH-1:0] product,
    input  logic                     acc_load,
    input  logic                     acc_en,
    input  logic                     acc_clr,
    output logic [ACC_WIDTH-1:0]     acc_value,
    output logic                     acc_ovf
);

    // One extra bit catches the carry out
    logic [ACC_WIDTH:0] sum_ext;

    assign sum_ext = {1'b0, acc_value} +
                     {{(ACC_WIDTH + 1 - PRODUCT_WIDTH){1'b0}}, product};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_value <= '0;
            acc_ovf   <= 1'b0;
        end else if (acc_clr) begin
            acc_value <= '0;
            acc_ovf   <= 1'b0;
        end else if (acc_load && acc_en) begin
            acc_value <= sum_ext[ACC_WIDTH-1:0];
            if (sum_ext[ACC_WIDTH]) begin
                acc_ovf <= 1'b1;
            end
        end
    end

endmodule

/* hdl/mul_control.sv */
`timescale 1ns/1ns
//////////////////////////////////////////////////
// Needs ADDR_WIDTH of 3 or more, upper slots read 0
// Product is captured one clock after the start write
//////////////////////////////////////////////////
module mul_control
    import mul_periph_pkg::*;
#(
    parameter int ADDR_WIDTH = 3
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [(2**ADDR_WIDTH)-1:0] wr_sel_n,
    input  logic [(2**ADDR_WIDTH)-1:0] rd_sel_n,
    input  logic [OPERAND_WIDTH-1:0]   wdata,
    output logic [OPERAND_WIDTH-1:0]   op_a,
    output logic [OPERAND_WIDTH-1:0]   op_b,
    input  logic [PRODUCT_WIDTH-1:0]   product,
    input  logic [ACC_WIDTH-1:0]       acc_value,
    input  logic                       acc_ovf,
    output logic                       acc_load,
    output logic                       acc_en,
    output logic                       acc_clr,
    output logic [RDATA_WIDTH-1:0]     rdata
);

    logic [OPERAND_WIDTH-1:0] op_a_reg;
    logic [OPERAND_WIDTH-1:0] op_b_reg;
    logic [PRODUCT_WIDTH-1:0] prod_reg;
    logic                     in_valid;
    logic                     in_acc;
    logic                     done;
    logic                     wr_ctrl;
    logic                     start;
    logic [RDATA_WIDTH-1:0]   status;

    assign wr_ctrl = ~wr_sel_n[ADDR_CTRL];
    assign start   = wr_ctrl & wdata[CTRL_START];
    assign acc_clr = wr_ctrl & wdata[CTRL_ACC_CLR];

    // Input stage feeds the multiplier, its valid doubles as busy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_a <= '0;
            op_b <= '0;
        end else if (start) begin
            op_a <= op_a_reg;
            op_b <= op_b_reg;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_a_reg <= '0;
            op_b_reg <= '0;
            prod_reg <= '0;
            in_valid <= 1'b0;
            in_acc   <= 1'b0;
            done     <= 1'b0;
        end else begin
            if (!wr_sel_n[ADDR_OP_A]) begin
                op_a_reg <= wdata;
            end
            if (!wr_sel_n[ADDR_OP_B]) begin
                op_b_reg <= wdata;
            end
            in_valid <= start;
            in_acc   <= start & wdata[CTRL_ACC_EN];
            // Capture stage
            if (in_valid) begin
                prod_reg <= product;
            end
            // A new start hides done of the one still finishing
            if (start) begin
                done <= 1'b0;
            end else if (in_valid) begin
                done <= 1'b1;
            end
        end
    end

    assign acc_load = in_valid;
    assign acc_en   = in_acc;

    always_comb begin
        status            = '0;
        status[STAT_BUSY] = in_valid;
        status[STAT_DONE] = done;
        status[STAT_OVF]  = acc_ovf;
    end

    // Selects are one-hot, so at most one branch is taken
    always_comb begin
        rdata = '0;
        if (!rd_sel_n[ADDR_OP_A]) begin
            rdata = {{(RDATA_WIDTH - OPERAND_WIDTH){1'b0}}, op_a_reg};
        end
        if (!rd_sel_n[ADDR_OP_B]) begin
            rdata = {{(RDATA_WIDTH - OPERAND_WIDTH){1'b0}}, op_b_reg};
        end
        if (!rd_sel_n[ADDR_PROD]) begin
            rdata = prod_reg;
        end
        if (!rd_sel_n[ADDR_ACC_LO]) begin
            rdata = acc_value[RDATA_WIDTH-1:0];
        end
        if (!rd_sel_n[ADDR_ACC_HI]) begin
            rdata = {{(2 * RDATA_WIDTH - ACC_WIDTH){1'b0}},
                     acc_value[ACC_WIDTH-1:RDATA_WIDTH]};
        end
        if (!rd_sel_n[ADDR_STATUS]) begin
            rdata = status;
        end
        if (!rd_sel_n[ADDR_ID]) begin
            rdata = PERIPH_ID;
        end
    end

endmodule

/* hdl/mul_periph.sv */
`timescale 1ns/1ns
//////////////////////////////////////////////////
// Plain strobe bus without wait states
// Reads are combinational, writes land on clk
//////////////////////////////////////////////////
module mul_periph
    import mul_periph_pkg::*;
#(
    parameter int ADDR_WIDTH = 3
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [ADDR_WIDTH-1:0]    address,
    input  logic                     wr,
    input  logic                     rd,
    input  logic [OPERAND_WIDTH-1:0] wdata,
    output logic [RDATA_WIDTH-1:0]   rdata
);

    logic [(2**ADDR_WIDTH)-1:0] wr_sel_n;
    logic [(2**ADDR_WIDTH)-1:0] rd_sel_n;
    logic [OPERAND_WIDTH-1:0]   op_a;
    logic [OPERAND_WIDTH-1:0]   op_b;
    logic [PRODUCT_WIDTH-1:0]   product;
    logic [ACC_WIDTH-1:0]       acc_value;
    logic                       acc_ovf;
    logic                       acc_load;
    logic                       acc_en;
    logic                       acc_clr;

    reg_select_decoder #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) i_reg_select_decoder (
        .address (address),
        .wr      (wr),
        .rd      (rd),
        .wr_sel_n(wr_sel_n),
        .rd_sel_n(rd_sel_n)
    );

    mul_control #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) i_mul_control (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_sel_n (wr_sel_n),
        .rd_sel_n (rd_sel_n),
        .wdata    (wdata),
        .op_a     (op_a),
        .op_b     (op_b),
        .product  (product),
        .acc_value(acc_value),
        .acc_ovf  (acc_ovf),
        .acc_load (acc_load),
        .acc_en   (acc_en),
        .acc_clr  (acc_clr),
        .rdata    (rdata)
    );

    wallace_multiplier i_wallace_multiplier (
        .op_a   (op_a),
        .op_b   (op_b),
        .product(product)
    );

    mac_accumulator i_mac_accumulator (
        .clk      (clk),
        .rst_n    (rst_n),
        .product  (product),
        .acc_load (acc_load),
        .acc_en   (acc_en),
        .acc_clr  (acc_clr),
        .acc_value(acc_value),
        .acc_ovf  (acc_ovf)
    );

endmodule

/* hdl/mul_periph_pkg.sv */
//////////////////////////////////////////////////
// Register map assumes at least 3 address bits
// Widths are fixed for the unsigned 8x8 datapath
//////////////////////////////////////////////////
package mul_periph_pkg;

    // Datapath widths
    localparam int OPERAND_WIDTH = 8;
    localparam int PRODUCT_WIDTH = 16;
    localparam int ACC_WIDTH     = 24;
    localparam int RDATA_WIDTH   = 16;

    // Register slots
    localparam logic [2:0] ADDR_OP_A   = 3'd0;
    localparam logic [2:0] ADDR_OP_B   = 3'd1;
    localparam logic [2:0] ADDR_CTRL   = 3'd2;
    localparam logic [2:0] ADDR_PROD   = 3'd3;
    localparam logic [2:0] ADDR_ACC_LO = 3'd4;
    localparam logic [2:0] ADDR_ACC_HI = 3'd5;
    localparam logic [2:0] ADDR_STATUS = 3'd6;
    localparam logic [2:0] ADDR_ID     = 3'd7;

    // CTRL write bits
    localparam int CTRL_START   = 0;
    localparam int CTRL_ACC_EN  = 1;
    localparam int CTRL_ACC_CLR = 2;

    // STATUS read bits
    localparam int STAT_BUSY = 0;
    localparam int STAT_DONE = 1;
    localparam int STAT_OVF  = 2;

    localparam logic [15:0] PERIPH_ID = 16'h4D55;

endpackage

/* hdl/reg_select_decoder.sv */
`timescale 1ns/1ns
//////////////////////////////////////////////////
// Selects are active low, one bit per slot
// All selects stay high while their strobe is low
//////////////////////////////////////////////////
module reg_select_decoder #(
    parameter int ADDR_WIDTH = 3
) (
    input  logic [ADDR_WIDTH-1:0]      address,
    input  logic                       wr,
    input  logic                       rd,
    output logic [(2**ADDR_WIDTH)-1:0] wr_sel_n,
    output logic [(2**ADDR_WIDTH)-1:0] rd_sel_n
);

    // Start inactive, then pull the addressed slot low
    always_comb begin
        wr_sel_n = '1;
        rd_sel_n = '1;
        if (wr) begin
            wr_sel_n[address] = 1'b0;
        end
        if (rd) begin
            rd_sel_n[address] = 1'b0;
        end
    end

endmodule

/* hdl/wallace_multiplier.sv */
`timescale 1ns/1ns
//////////////////////////////////////////////////
// Unsigned operands only, purely combinational
// Carries out of the top column are always zero
//////////////////////////////////////////////////
module wallace_multiplier
    import mul_periph_pkg::*;
(
    input  logic [OPERAND_WIDTH-1:0] op_a,
    input  logic [OPERAND_WIDTH-1:0] op_b,
    output logic [PRODUCT_WIDTH-1:0] product
);

    localparam int W  = OPERAND_WIDTH;
    localparam int PW = PRODUCT_WIDTH;

    // Height of column col after lvl reduction levels
    function automatic int col_height(input int lvl, input int col);
        int h [PW];
        int nh [PW];
        if (col >= PW) begin
            return 0;
        end
        for (int c = 0; c < PW; c++) begin
            h[c] = (c < W) ? c + 1 : PW - 1 - c;
        end
        for (int l = 0; l < lvl; l++) begin
            for (int c = 0; c < PW; c++) begin
                // Own sums and passthroughs, then carries from the column below
                nh[c] = h[c] / 3 + ((h[c] % 3 != 0) ? 1 : 0);
                if (c > 0) begin
                    nh[c] += h[c-1] / 3 + ((h[c-1] % 3 == 2) ? 1 : 0);
                end
            end
            for (int c = 0; c < PW; c++) begin
                h[c] = nh[c];
            end
        end
        return h[col];
    endfunction

    // Bits a column keeps for itself at the next level
    function automatic int own_count(input int lvl, input int col);
        int h;
        h = col_height(lvl, col);
        return h / 3 + ((h % 3 != 0) ? 1 : 0);
    endfunction

    function automatic int num_levels();
        int lvl;
        int peak;
        lvl = 0;
        peak = W;
        while (peak > 2) begin
            lvl++;
            peak = 0;
            for (int c = 0; c < PW; c++) begin
                if (col_height(lvl, c) > peak) begin
                    peak = col_height(lvl, c);
                end
            end
        end
        return lvl;
    endfunction

    localparam int NL = num_levels();

    // Column bits per level, unused slots tied low
    wire bits [0:NL][0:PW-1][0:W-1];
    wire [PW-1:0] row_s;
    wire [PW-1:0] row_c;
    wire [PW-1:0] carry;

    // Partial products, stacked by weight
    for (genvar i = 0; i < W; i++) begin : g_pp_i
        for (genvar j = 0; j < W; j++) begin : g_pp_j
            localparam int COL = i + j;
            localparam int IDX = (COL < W) ? i : i - (COL - W + 1);
            assign bits[0][COL][IDX] = op_a[j] & op_b[i];
        end
    end

    for (genvar l = 0; l <= NL; l++) begin : g_tie_l
        for (genvar c = 0; c < PW; c++) begin : g_tie_c
            localparam int H = col_height(l, c);
            for (genvar k = H; k < W; k++) begin : g_tie_k
                assign bits[l][c][k] = 1'b0;
            end
        end
    end

    for (genvar l = 0; l < NL; l++) begin : g_lvl
        for (genvar c = 0; c < PW; c++) begin : g_col
            localparam int H   = col_height(l, c);
            localparam int NFA = H / 3;
            localparam int REM = H % 3;
            localparam int CB  = own_count(l, c + 1);

            // 3:2 compressors
            for (genvar k = 0; k < NFA; k++) begin : g_fa
                wire x = bits[l][c][3*k];
                wire y = bits[l][c][3*k+1];
                wire z = bits[l][c][3*k+2];
                assign bits[l+1][c][k] = x ^ y ^ z;
                if (c + 1 < PW) begin : g_cout
                    assign bits[l+1][c+1][CB+k] = (x & y) | (x & z) | (y & z);
                end
            end

            // 2:2 compressor for a pair, a lone bit passes through
            if (REM == 2) begin : g_ha
                assign bits[l+1][c][NFA] = bits[l][c][3*NFA] ^ bits[l][c][3*NFA+1];
                if (c + 1 < PW) begin : g_cout
                    assign bits[l+1][c+1][CB+NFA] = bits[l][c][3*NFA] & bits[l][c][3*NFA+1];
                end
            end else if (REM == 1) begin : g_pass
                assign bits[l+1][c][NFA] = bits[l][c][3*NFA];
            end
        end
    end

    // Ripple carry-propagate adder over the last two rows
    assign carry[0] = 1'b0;
    for (genvar c = 0; c < PW; c++) begin : g_cpa
        assign row_s[c]   = bits[NL][c][0];
        assign row_c[c]   = bits[NL][c][1];
        assign product[c] = row_s[c] ^ row_c[c] ^ carry[c];
        if (c < PW - 1) begin : g_carry
            assign carry[c+1] = (row_s[c] & row_c[c]) | (row_s[c] & carry[c]) |
                                (row_c[c] & carry[c]);
        end
    end

endmodule

/* mul_periph.f */
hdl/mul_periph_pkg.sv
hdl/reg_select_decoder.sv
hdl/wallace_multiplier.sv
hdl/mac_accumulator.sv
hdl/mul_control.sv
hdl/mul_periph.sv
test/tb_mul_periph.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the mul_periph testbench with Verilator from the project root
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f mul_periph.f --top-module tb_mul_periph -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_mul_periph > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "RESULT: PASS" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* test/mul_periph_input.txt */
# cmd addr value (hex): W writes value to addr, R reads addr and expects value
# A W to CTRL (addr 2) with bit 0 set waits until STATUS shows done
W 0 00
W 1 37
W 2 01
R 3 0000
W 0 FF
W 1 FF
W 2 01
R 3 FE01
W 0 80
W 1 40
W 2 01
R 3 2000
W 0 01
W 1 B5
W 2 01
R 3 00B5
W 0 10
W 1 10
W 2 01
R 3 0100
R 0 0010
R 1 0010

/* test/tb_mul_periph.sv */
`timescale 1ns/1ns
//////////////////////////////////////////////////
// Run from the project root so the vector file is found
// Stops at the first mismatch or timeout
//////////////////////////////////////////////////
module tb_mul_periph
    import mul_periph_pkg::*;
;

    logic        clk;
    logic        rst_n;
    logic [2:0]  address;
    logic        wr;
    logic        rd;
    logic [7:0]  wdata;
    logic [15:0] rdata;
    logic [31:0] lcg_state;

    mul_periph #(
        .ADDR_WIDTH(3)
    ) i_mul_periph (
        .clk    (clk),
        .rst_n  (rst_n),
        .address(address),
        .wr     (wr),
        .rd     (rd),
        .wdata  (wdata),
        .rdata  (rdata)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // Bus tasks start and end on a falling edge
    task automatic bus_write(input logic [2:0] addr, input logic [7:0] data);
        address = addr;
        wdata   = data;
        wr      = 1'b1;
        @(negedge clk);
        wr = 1'b0;
    endtask

    task automatic bus_read(input logic [2:0] addr, output logic [15:0] data);
        address = addr;
        rd      = 1'b1;
        #10;
        data = rdata;
        @(negedge clk);
        rd = 1'b0;
    endtask

    task automatic read_check(input logic [2:0] addr, input logic [15:0] expected,
                              input string name);
        logic [15:0] value;
        bus_read(addr, value);
        check_value(name, expected, value);
    endtask

    task automatic wait_done(input string name);
        logic [15:0] st;
        bit          seen;
        seen = 1'b0;
        for (int i = 0; i < 50 && !seen; i++) begin
            bus_read(ADDR_STATUS, st);
            seen = st[STAT_DONE];
        end
        if (!seen) begin
            $display("ERROR %s: done never rose on STATUS within 50 cycles", name);
            $display("RESULT: FAIL");
            $fatal(1, "timeout waiting for done");
        end
    endtask

    task automatic run_multiply(input logic [7:0] a, input logic [7:0] b,
                                input logic [7:0] ctrl, input string name);
        bus_write(ADDR_OP_A, a);
        bus_write(ADDR_OP_B, b);
        bus_write(ADDR_CTRL, ctrl);
        wait_done(name);
    endtask

    // Expects done set, as after any finished multiply
    task automatic check_acc(input string name, input logic [23:0] sum, input logic ovf);
        logic [15:0] exp_status;
        exp_status            = '0;
        exp_status[STAT_DONE] = 1'b1;
        exp_status[STAT_OVF]  = ovf;
        read_check(ADDR_ACC_LO, sum[15:0], {name, " acc_lo"});
        read_check(ADDR_ACC_HI, {8'h00, sum[23:16]}, {name, " acc_hi"});
        read_check(ADDR_STATUS, exp_status, {name, " status"});
    endtask

    initial begin
        int          fd;
        int          n;
        int          line_no;
        int          vec_count;
        string       line;
        logic [7:0]  cmd;
        logic [31:0] f_addr;
        logic [31:0] f_val;
        logic [7:0]  a1;
        logic [7:0]  a2;
        logic [7:0]  b1;
        logic [15:0] p1;
        logic [15:0] p2;
        logic [63:0] acc_true;
        logic        use_acc;

        clk     = 1'b0;
        rst_n   = 1'b0;
        address = '0;
        wr      = 1'b0;
        rd      = 1'b0;
        wdata   = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Reset values and operand readback
        for (int s = 0; s < 8; s++) begin
            read_check(s[2:0], (s == 7) ? PERIPH_ID : 16'h0000,
                       $sformatf("reset slot %0d", s));
        end
        bus_write(ADDR_OP_A, 8'hA5);
        bus_write(ADDR_OP_B, 8'h3C);
        read_check(ADDR_OP_A, 16'h00A5, "op_a readback");
        read_check(ADDR_OP_B, 16'h003C, "op_b readback");

        // Directed vectors
        fd = $fopen("test/mul_periph_input.txt", "r");
        if (fd == 0) begin
            $display("ERROR: could not open test/mul_periph_input.txt");
            $display("RESULT: FAIL");
            $fatal(1, "missing vector file");
        end
        line_no   = 0;
        vec_count = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%c %h %h", cmd, f_addr, f_val);
                if (n == 3) begin
                    vec_count++;
                    if (cmd == "W") begin
                        bus_write(f_addr[2:0], f_val[7:0]);
                        if (f_addr[2:0] == ADDR_CTRL && f_val[CTRL_START]) begin
                            wait_done($sformatf("vector line %0d", line_no));
                        end
                    end else if (cmd == "R") begin
                        read_check(f_addr[2:0], f_val[15:0],
                                   $sformatf("vector line %0d", line_no));
                    end else begin
                        $display("ERROR: unknown command on vector line %0d", line_no);
                        $display("RESULT: FAIL");
                        $fatal(1, "bad vector file");
                    end
                end
            end
        end
        $fclose(fd);
        if (vec_count == 0) begin
            $display("ERROR: the vector file holds no vectors");
            $display("RESULT: FAIL");
            $fatal(1, "empty vector file");
        end

        // Random operand pairs
        lcg_state = 32'h4907;
        for (int k = 0; k < 200; k++) begin
            lcg_state = lcg_next(lcg_state);
            a1 = lcg_state[23:16];
            b1 = lcg_state[31:24];
            p1 = {8'h00, a1} * {8'h00, b1};
            run_multiply(a1, b1, 8'h01, "random");
            read_check(ADDR_PROD, p1, $sformatf("random pair %0d", k));
        end

        // Accumulation past 24 bits, every eighth start without accumulation
        bus_write(ADDR_CTRL, 8'h04);
        acc_true = '0;
        check_acc("after clear", 24'h0, 1'b0);
        for (int k = 0; k < 400; k++) begin
            lcg_state = lcg_next(lcg_state);
            a1 = {3'b111, lcg_state[20:16]};
            b1 = {3'b111, lcg_state[28:24]};
            use_acc = ((k % 8) != 7);
            run_multiply(a1, b1, use_acc ? 8'h03 : 8'h01, "accumulate");
            if (use_acc) begin
                acc_true = acc_true + {56'h0, a1} * {56'h0, b1};
            end
            check_acc($sformatf("accumulate step %0d", k), acc_true[23:0],
                      acc_true > 64'h0000_0000_00FF_FFFF);
        end
        bus_write(ADDR_CTRL, 8'h04);
        check_acc("clear after overflow", 24'h0, 1'b0);

        // Clear in the same write as a start, add begins from zero
        run_multiply(8'h12, 8'h34, 8'h03, "pre-sum");
        run_multiply(8'h05, 8'h07, 8'h07, "clear and start");
        check_acc("clear and start", 24'h000023, 1'b0);

        // One write per cycle, so consecutive starts share the operand registers
        a1 = 8'h9B;
        a2 = 8'hD2;
        b1 = 8'h4E;
        p1 = {8'h00, a1} * {8'h00, b1};
        p2 = {8'h00, a2} * {8'h00, b1};
        bus_write(ADDR_CTRL, 8'h04);
        bus_write(ADDR_OP_A, a1);
        bus_write(ADDR_OP_B, b1);
        bus_write(ADDR_CTRL, 8'h03);
        bus_write(ADDR_OP_A, a2);
        bus_write(ADDR_CTRL, 8'h03);
        bus_write(ADDR_CTRL, 8'h03);
        wait_done("back-to-back");
        read_check(ADDR_PROD, p2, "back-to-back prod");
        acc_true = {48'h0, p1} + {48'h0, p2} + {48'h0, p2};
        check_acc("back-to-back", acc_true[23:0], 1'b0);

        $display("RESULT: PASS");
        $finish;
    end

endmodule
